//--- clock_timer.sv
`timescale 1ns/1ps
`include "mcu_io_defs.svh"

module clock_timer (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     tick_256hz,
  input  logic                     clear,
  output mcu_io_pkg::tick_count_t  count,
  output logic [`MCU_IO_TAPS-1:0]  tap_fall
);

  // Bit 0 toggles at 128 Hz, bit 7 at 1 Hz
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (tick_256hz) begin
      count <= count + 1'b1;
    end
  end

  // A bit falls on the next tick when it and all lower bits are ones,
  // so the strobe is a carry chain starting from the tick itself
  assign tap_fall[0] = tick_256hz & count[0];

  generate
    for (genvar i = 1; i < `MCU_IO_TAPS; i++) begin : g_tap
      assign tap_fall[i] = tap_fall[i-1] & count[i];
    end
  endgenerate

endmodule

//--- input_port.sv
`timescale 1ns/1ps

module input_port (
  input  logic                 clk,
  input  logic                 reset_n,
  input  mcu_io_pkg::nibble_t  k0,
  input  mcu_io_pkg::nibble_t  relation,
  output mcu_io_pkg::nibble_t  level,
  output mcu_io_pkg::nibble_t  edge_event
);

  mcu_io_pkg::nibble_t sync_1;
  mcu_io_pkg::nibble_t sync_2;
  mcu_io_pkg::nibble_t prev;
  mcu_io_pkg::nibble_t rising;
  mcu_io_pkg::nibble_t falling;

  // Two-stage synchronizer plus one stage of history
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sync_1 <= '0;
      sync_2 <= '0;
      prev   <= '0;
    end else begin
      sync_1 <= k0;
      sync_2 <= sync_1;
      prev   <= sync_2;
    end
  end

  assign level = sync_2;

  assign rising  = sync_2 & ~prev;
  assign falling = ~sync_2 & prev;

  // Relation 1 selects the falling edge, 0 the rising edge
  assign edge_event = (relation & falling) | (~relation & rising);

endmodule

//--- io_register_file.sv
`timescale 1ns/1ps
`include "mcu_io_defs.svh"

module io_register_file (
  input  logic                     clk,
  input  logic                     reset_n,
  input  mcu_io_pkg::apb_req_t     apb_req,
  output mcu_io_pkg::apb_rsp_t     apb_rsp,
  input  mcu_io_pkg::tick_count_t  count,
  input  logic [`MCU_IO_TAPS-1:0]  tap_fall,
  input  mcu_io_pkg::pt_count_t    pt_value,
  input  logic                     pt_underflow,
  input  mcu_io_pkg::nibble_t      k0_level,
  input  mcu_io_pkg::nibble_t      k0_edge,
  output logic                     clock_clear,
  output mcu_io_pkg::pt_ctrl_t     pt_ctrl,
  output mcu_io_pkg::nibble_t      relation,
  output mcu_io_pkg::irq_req_t     irq
);

  mcu_io_pkg::apb_state_t state;
  mcu_io_pkg::apb_state_t state_next;

  logic access;
  logic wr;
  logic rd;
  logic hit;
  mcu_io_pkg::nibble_t rdata;

  mcu_io_pkg::nibble_t clock_mask;
  logic                pt_mask;
  mcu_io_pkg::nibble_t k0_mask;

  mcu_io_pkg::nibble_t clock_factor;
  logic                pt_factor;
  logic                k0_factor;
  mcu_io_pkg::nibble_t clock_set;

  // Bus phase tracking
  always_comb begin
    if (!apb_req.psel) begin
      state_next = mcu_io_pkg::st_idle;
    end else if (!apb_req.penable) begin
      state_next = mcu_io_pkg::st_setup;
    end else begin
      state_next = mcu_io_pkg::st_access;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= mcu_io_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Access phase only counts when it follows a setup phase
  assign access = apb_req.psel & apb_req.penable & (state == mcu_io_pkg::st_setup);
  assign wr     = access & apb_req.pwrite;
  assign rd     = access & ~apb_req.pwrite;

  // Read mux and offset decode
  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (apb_req.paddr)
      `ADDR_CLK_FACTOR:   rdata = clock_factor;
      `ADDR_PT_FACTOR:    rdata = {3'b0, pt_factor};
      `ADDR_K0_FACTOR:    rdata = {3'b0, k0_factor};
      `ADDR_CLK_MASK:     rdata = clock_mask;
      `ADDR_PT_MASK:      rdata = {3'b0, pt_mask};
      `ADDR_K0_MASK:      rdata = k0_mask;
      `ADDR_CLK_LO:       rdata = count[3:0];
      `ADDR_CLK_HI:       rdata = count[7:4];
      `ADDR_PT_CNT_LO:    rdata = pt_value[3:0];
      `ADDR_PT_CNT_HI:    rdata = pt_value[7:4];
      `ADDR_PT_RELOAD_LO: rdata = pt_ctrl.reload[3:0];
      `ADDR_PT_RELOAD_HI: rdata = pt_ctrl.reload[7:4];
      `ADDR_K0_VALUE:     rdata = k0_level;
      `ADDR_K0_RELATION:  rdata = relation;
      // Write only, reads as zero
      `ADDR_TIMER_RESET:  rdata = '0;
      `ADDR_PT_CONTROL:   rdata = {3'b0, pt_ctrl.enable};
      `ADDR_PT_SELECT:    rdata = {1'b0, pt_ctrl.tap_sel};
      default:            hit = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = (rd && hit) ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~hit;

  // Control registers and one-cycle pulses
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clock_clear <= 1'b0;
      pt_ctrl     <= '0;
      relation    <= 4'hF;
      clock_mask  <= '0;
      pt_mask     <= 1'b0;
      k0_mask     <= '0;
    end else begin
      clock_clear  <= 1'b0;
      pt_ctrl.load <= 1'b0;
      if (wr) begin
        case (apb_req.paddr)
          `ADDR_CLK_MASK:     clock_mask <= apb_req.pwdata;
          `ADDR_PT_MASK:      pt_mask <= apb_req.pwdata[0];
          `ADDR_K0_MASK:      k0_mask <= apb_req.pwdata;
          `ADDR_PT_RELOAD_LO: pt_ctrl.reload[3:0] <= apb_req.pwdata;
          `ADDR_PT_RELOAD_HI: pt_ctrl.reload[7:4] <= apb_req.pwdata;
          `ADDR_K0_RELATION:  relation <= apb_req.pwdata;
          `ADDR_TIMER_RESET:  clock_clear <= apb_req.pwdata[1];
          `ADDR_PT_CONTROL: begin
            // Bit 1 reloads the counter, bit 0 runs it
            pt_ctrl.load   <= apb_req.pwdata[1];
            pt_ctrl.enable <= apb_req.pwdata[0];
          end
          `ADDR_PT_SELECT:    pt_ctrl.tap_sel <= apb_req.pwdata[2:0];
          default: begin
          end
        endcase
      end
    end
  end

  // 32, 8, 2 and 1 Hz falling edges
  assign clock_set = {tap_fall[2], tap_fall[4], tap_fall[6], tap_fall[7]};

  // Factor flags, a new event beats a clearing read on the same edge
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clock_factor <= '0;
      pt_factor    <= 1'b0;
      k0_factor    <= 1'b0;
    end else begin
      if (rd && apb_req.paddr == `ADDR_CLK_FACTOR) begin
        clock_factor <= clock_set;
      end else begin
        clock_factor <= clock_factor | clock_set;
      end
      if (rd && apb_req.paddr == `ADDR_PT_FACTOR) begin
        pt_factor <= pt_underflow;
      end else begin
        pt_factor <= pt_factor | pt_underflow;
      end
      if (rd && apb_req.paddr == `ADDR_K0_FACTOR) begin
        k0_factor <= |(k0_edge & k0_mask);
      end else begin
        k0_factor <= k0_factor | (|(k0_edge & k0_mask));
      end
    end
  end

  // Request lines trail factor and mask by one edge
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      irq <= '0;
    end else begin
      irq.clock      <= |(clock_factor & clock_mask);
      irq.prog_timer <= pt_factor & pt_mask;
      irq.input_k0   <= k0_factor & (|k0_mask);
    end
  end

endmodule

//--- mcu_io_defs.svh
`ifndef MCU_IO_DEFS_SVH
`define MCU_IO_DEFS_SVH

// Bus and field widths
`define MCU_IO_ADDR_W 8
`define MCU_IO_DATA_W 4
`define MCU_IO_TAPS 8
`define MCU_IO_PT_W 8
`define MCU_IO_SEL_W 3

// Interrupt factor flags, cleared on read
`define ADDR_CLK_FACTOR 8'h00
`define ADDR_PT_FACTOR 8'h02
`define ADDR_K0_FACTOR 8'h04

// Interrupt masks
`define ADDR_CLK_MASK 8'h10
`define ADDR_PT_MASK 8'h12
`define ADDR_K0_MASK 8'h14

// Counter values and reload
`define ADDR_CLK_LO 8'h20
`define ADDR_CLK_HI 8'h21
`define ADDR_PT_CNT_LO 8'h24
`define ADDR_PT_CNT_HI 8'h25
`define ADDR_PT_RELOAD_LO 8'h26
`define ADDR_PT_RELOAD_HI 8'h27

// Input port K0
`define ADDR_K0_VALUE 8'h40
`define ADDR_K0_RELATION 8'h41

// Timer control
`define ADDR_TIMER_RESET 8'h76
`define ADDR_PT_CONTROL 8'h78
`define ADDR_PT_SELECT 8'h79

`endif

//--- mcu_io_pkg.sv
`include "mcu_io_defs.svh"

package mcu_io_pkg;

  typedef logic [`MCU_IO_DATA_W-1:0] nibble_t;
  typedef logic [`MCU_IO_ADDR_W-1:0] io_addr_t;
  typedef logic [`MCU_IO_TAPS-1:0] tick_count_t;
  typedef logic [`MCU_IO_PT_W-1:0] pt_count_t;
  typedef logic [`MCU_IO_SEL_W-1:0] tap_sel_t;

  // Transfer phase as seen by the slave
  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } apb_state_t;

  // Master side of the bus
  typedef struct packed {
    logic     psel;
    logic     penable;
    logic     pwrite;
    io_addr_t paddr;
    nibble_t  pwdata;
  } apb_req_t;

  // Slave side of the bus
  typedef struct packed {
    nibble_t prdata;
    logic    pready;
    logic    pslverr;
  } apb_rsp_t;

  // Programmable timer controls, load is a one-cycle pulse
  typedef struct packed {
    logic      enable;
    logic      load;
    tap_sel_t  tap_sel;
    pt_count_t reload;
  } pt_ctrl_t;

  typedef struct packed {
    logic clock;
    logic prog_timer;
    logic input_k0;
  } irq_req_t;

endpackage

//--- mcu_io_top.sv
`timescale 1ns/1ps
`include "mcu_io_defs.svh"

module mcu_io_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  tick_256hz,
  input  mcu_io_pkg::nibble_t   k0,
  input  mcu_io_pkg::apb_req_t  apb_req,
  output mcu_io_pkg::apb_rsp_t  apb_rsp,
  output mcu_io_pkg::irq_req_t  irq
);

  mcu_io_pkg::tick_count_t  count;
  logic [`MCU_IO_TAPS-1:0]  tap_fall;
  logic                     clock_clear;
  mcu_io_pkg::pt_ctrl_t     pt_ctrl;
  mcu_io_pkg::pt_count_t    pt_value;
  logic                     pt_underflow;
  mcu_io_pkg::nibble_t      relation;
  mcu_io_pkg::nibble_t      k0_level;
  mcu_io_pkg::nibble_t      k0_edge;

  clock_timer u_clock_timer (
    .clk        (clk),
    .reset_n    (reset_n),
    .tick_256hz (tick_256hz),
    .clear      (clock_clear),
    .count      (count),
    .tap_fall   (tap_fall)
  );

  prog_timer u_prog_timer (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl      (pt_ctrl),
    .tap_fall  (tap_fall),
    .value     (pt_value),
    .underflow (pt_underflow)
  );

  input_port u_input_port (
    .clk        (clk),
    .reset_n    (reset_n),
    .k0         (k0),
    .relation   (relation),
    .level      (k0_level),
    .edge_event (k0_edge)
  );

  io_register_file u_io_register_file (
    .clk          (clk),
    .reset_n      (reset_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .count        (count),
    .tap_fall     (tap_fall),
    .pt_value     (pt_value),
    .pt_underflow (pt_underflow),
    .k0_level     (k0_level),
    .k0_edge      (k0_edge),
    .clock_clear  (clock_clear),
    .pt_ctrl      (pt_ctrl),
    .relation     (relation),
    .irq          (irq)
  );

endmodule

//--- prog_timer.sv
`timescale 1ns/1ps
`include "mcu_io_defs.svh"

module prog_timer (
  input  logic                     clk,
  input  logic                     reset_n,
  input  mcu_io_pkg::pt_ctrl_t     ctrl,
  input  logic [`MCU_IO_TAPS-1:0]  tap_fall,
  output mcu_io_pkg::pt_count_t    value,
  output logic                     underflow
);

  logic step;
  logic at_zero;

  // Count on the falling edge of the selected divider bit
  assign step    = ctrl.enable & tap_fall[ctrl.tap_sel];
  assign at_zero = (value == '0);

  // Load has priority and swallows a coinciding step
  assign underflow = ~ctrl.load & step & at_zero;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      value <= '0;
    end else if (ctrl.load) begin
      value <= ctrl.reload;
    end else if (step) begin
      if (at_zero) begin
        // Stepping past zero wraps to the reload value
        value <= ctrl.reload;
      end else begin
        value <= value - 1'b1;
      end
    end
  end

endmodule

//--- sim.f
+incdir+.
mcu_io_pkg.sv
clock_timer.sv
prog_timer.sv
input_port.sv
io_register_file.sv
mcu_io_top.sv
tb_checker.sv
tb_mcu_io.sv

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                  clk,
  input  logic                  reset_n,
  input  mcu_io_pkg::apb_req_t  apb_req,
  input  mcu_io_pkg::apb_rsp_t  apb_rsp,
  input  mcu_io_pkg::irq_req_t  irq,
  input  logic                  exp_valid,
  input  mcu_io_pkg::nibble_t   exp_data,
  input  logic                  exp_err,
  input  logic                  irq_valid,
  input  mcu_io_pkg::irq_req_t  exp_irq,
  output int                    bus_errors,
  output int                    irq_errors
);

  int bus_count = 0;
  int irq_count = 0;

  assign bus_errors = bus_count;
  assign irq_errors = irq_count;

  task automatic report_mismatch(input string name, input logic [3:0] expected,
                                 input logic [3:0] actual);
    $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  // Sampled at the edge that ends each access cycle
  always @(posedge clk) begin
    if (exp_valid && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
      if (apb_rsp.pslverr !== exp_err) begin
        report_mismatch("pslverr", {3'b0, exp_err}, {3'b0, apb_rsp.pslverr});
        bus_count++;
      end
      if (!apb_req.pwrite && apb_rsp.prdata !== exp_data) begin
        report_mismatch("prdata", exp_data, apb_rsp.prdata);
        bus_count++;
      end
    end
    // No error response outside a transfer
    if (reset_n && !apb_req.psel && apb_rsp.pslverr !== 1'b0) begin
      report_mismatch("pslverr while idle", 4'h0, {3'b0, apb_rsp.pslverr});
      bus_count++;
    end
    if (irq_valid && irq !== exp_irq) begin
      report_mismatch("irq", {1'b0, exp_irq}, {1'b0, irq});
      irq_count++;
    end
  end

endmodule

//--- tb_mcu_io.sv
`timescale 1ns/1ps
`include "mcu_io_defs.svh"

module tb_mcu_io;

  typedef enum logic [2:0] {
    op_write,
    op_read,
    op_read_model,
    op_read_bad,
    op_ticks,
    op_pins
  } op_t;

  typedef struct packed {
    op_t                  op;
    mcu_io_pkg::io_addr_t addr;
    mcu_io_pkg::nibble_t  data;
    logic [15:0]          count;
    mcu_io_pkg::nibble_t  exp;
  } entry_t;

  // Reference model of counters, controls and factor flags
  typedef struct packed {
    mcu_io_pkg::tick_count_t count;
    mcu_io_pkg::pt_count_t   pt_val;
    mcu_io_pkg::pt_count_t   reload;
    mcu_io_pkg::tap_sel_t    sel;
    logic                    enable;
    mcu_io_pkg::nibble_t     clk_mask;
    logic                    pt_mask;
    mcu_io_pkg::nibble_t     k0_mask;
    mcu_io_pkg::nibble_t     relation;
    mcu_io_pkg::nibble_t     pins;
    mcu_io_pkg::nibble_t     clk_factor;
    logic                    pt_factor;
    logic                    k0_factor;
  } model_t;

  logic                 clk;
  logic                 reset_n;
  logic                 tick_256hz;
  mcu_io_pkg::nibble_t  k0;
  mcu_io_pkg::apb_req_t apb_req;
  mcu_io_pkg::apb_rsp_t apb_rsp;
  mcu_io_pkg::irq_req_t irq;
  logic                 exp_valid;
  mcu_io_pkg::nibble_t  exp_data;
  logic                 exp_err;
  logic                 irq_valid;
  mcu_io_pkg::irq_req_t exp_irq;
  int                   bus_errors;
  int                   irq_errors;

  entry_t      table_q[$];
  bit          table_ready = 1'b0;
  logic [31:0] lcg_state = 32'd88;
  model_t      m;

  mcu_io_top u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .tick_256hz (tick_256hz),
    .k0         (k0),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .irq        (irq)
  );

  tb_checker u_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .irq        (irq),
    .exp_valid  (exp_valid),
    .exp_data   (exp_data),
    .exp_err    (exp_err),
    .irq_valid  (irq_valid),
    .exp_irq    (exp_irq),
    .bus_errors (bus_errors),
    .irq_errors (irq_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic mcu_io_pkg::nibble_t lcg_nibble();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[27:24];
  endfunction

  function automatic void push_entry(input op_t op, input mcu_io_pkg::io_addr_t addr,
                                     input mcu_io_pkg::nibble_t data, input int count,
                                     input mcu_io_pkg::nibble_t exp);
    table_q.push_back(entry_t'{op, addr, data, 16'(count), exp});
  endfunction

  // Random write that also sets every bit outside the field
  function automatic void push_readback(input mcu_io_pkg::io_addr_t addr,
                                        input mcu_io_pkg::nibble_t field);
    mcu_io_pkg::nibble_t v;
    v = lcg_nibble() | ~field;
    push_entry(op_write, addr, v, 0, 4'h0);
    push_entry(op_read, addr, 4'h0, 0, v & field);
  endfunction

  function automatic void advance_model_tick();
    logic [7:0]  fall;
    logic [15:0] low;
    // Tap i falls when bits i down to 0 are all ones at the tick
    for (int i = 0; i < 8; i++) begin
      low     = (16'd1 << (i + 1)) - 16'd1;
      fall[i] = (({8'd0, m.count} & low) == low);
    end
    if (m.enable && fall[m.sel]) begin
      if (m.pt_val == '0) begin
        m.pt_val    = m.reload;
        m.pt_factor = 1'b1;
      end else begin
        m.pt_val = m.pt_val - 8'd1;
      end
    end
    m.clk_factor = m.clk_factor | {fall[2], fall[4], fall[6], fall[7]};
    m.count      = m.count + 8'd1;
  endfunction

  function automatic void apply_pin_change(input mcu_io_pkg::nibble_t pins);
    for (int i = 0; i < 4; i++) begin
      // Relation 1 waits for a new 0, relation 0 for a new 1
      if (m.k0_mask[i] && pins[i] != m.pins[i] && pins[i] != m.relation[i]) begin
        m.k0_factor = 1'b1;
      end
    end
    m.pins = pins;
  endfunction

  function automatic void record_write(input mcu_io_pkg::io_addr_t addr,
                                       input mcu_io_pkg::nibble_t data);
    case (addr)
      `ADDR_CLK_MASK:     m.clk_mask = data;
      `ADDR_PT_MASK:      m.pt_mask = data[0];
      `ADDR_K0_MASK:      m.k0_mask = data;
      `ADDR_PT_RELOAD_LO: m.reload[3:0] = data;
      `ADDR_PT_RELOAD_HI: m.reload[7:4] = data;
      `ADDR_K0_RELATION:  m.relation = data;
      `ADDR_PT_SELECT:    m.sel = data[2:0];
      `ADDR_TIMER_RESET:  m.count = data[1] ? 8'd0 : m.count;
      `ADDR_PT_CONTROL: begin
        m.enable = data[0];
        m.pt_val = data[1] ? m.reload : m.pt_val;
      end
      default: begin
      end
    endcase
  endfunction

  function automatic mcu_io_pkg::nibble_t expected_read(input mcu_io_pkg::io_addr_t addr);
    case (addr)
      `ADDR_CLK_FACTOR: return m.clk_factor;
      `ADDR_PT_FACTOR:  return {3'b0, m.pt_factor};
      `ADDR_K0_FACTOR:  return {3'b0, m.k0_factor};
      `ADDR_CLK_LO:     return m.count[3:0];
      `ADDR_CLK_HI:     return m.count[7:4];
      `ADDR_PT_CNT_LO:  return m.pt_val[3:0];
      `ADDR_PT_CNT_HI:  return m.pt_val[7:4];
      `ADDR_K0_VALUE:   return m.pins;
      default:          return 4'h0;
    endcase
  endfunction

  function automatic void clear_on_read(input mcu_io_pkg::io_addr_t addr);
    case (addr)
      `ADDR_CLK_FACTOR: m.clk_factor = 4'h0;
      `ADDR_PT_FACTOR:  m.pt_factor = 1'b0;
      `ADDR_K0_FACTOR:  m.k0_factor = 1'b0;
      default: begin
      end
    endcase
  endfunction

  function automatic mcu_io_pkg::irq_req_t expected_irq();
    mcu_io_pkg::irq_req_t r;
    r.clock      = |(m.clk_factor & m.clk_mask);
    r.prog_timer = m.pt_factor & m.pt_mask;
    r.input_k0   = m.k0_factor & (|m.k0_mask);
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic bus_access(input logic write, input mcu_io_pkg::io_addr_t addr,
                            input mcu_io_pkg::nibble_t wdata,
                            input mcu_io_pkg::nibble_t rdata_exp, input logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    next_cycle();
    apb_req.penable = 1'b1;
    exp_data        = rdata_exp;
    exp_err         = err;
    exp_valid       = 1'b1;
    @(posedge clk);
    while (!apb_rsp.pready) @(posedge clk);
    #2;
    apb_req   = '0;
    exp_valid = 1'b0;
    if (!write) begin
      clear_on_read(addr);
    end
  endtask

  task automatic run_entry(input entry_t e);
    case (e.op)
      op_write: begin
        bus_access(1'b1, e.addr, e.data, 4'h0, 1'b0);
        record_write(e.addr, e.data);
      end
      op_read:       bus_access(1'b0, e.addr, 4'h0, e.exp, 1'b0);
      op_read_model: bus_access(1'b0, e.addr, 4'h0, expected_read(e.addr), 1'b0);
      op_read_bad:   bus_access(1'b0, e.addr, 4'h0, 4'h0, 1'b1);
      op_ticks: begin
        tick_256hz = 1'b1;
        repeat (e.count) begin
          advance_model_tick();
          next_cycle();
        end
        tick_256hz = 1'b0;
      end
      op_pins: begin
        k0 = e.data;
        apply_pin_change(e.data);
        repeat (e.count) next_cycle();
      end
      default: begin
      end
    endcase
    // irq trails its factor by one edge so it is sampled after an idle cycle
    next_cycle();
    exp_irq   = expected_irq();
    irq_valid = 1'b1;
    next_cycle();
    irq_valid = 1'b0;
  endtask

  task automatic build_table();
    mcu_io_pkg::nibble_t r;
    push_readback(`ADDR_CLK_MASK, 4'hF);
    push_readback(`ADDR_PT_MASK, 4'h1);
    push_readback(`ADDR_K0_MASK, 4'hF);
    push_readback(`ADDR_PT_RELOAD_LO, 4'hF);
    push_readback(`ADDR_PT_RELOAD_HI, 4'hF);
    push_readback(`ADDR_K0_RELATION, 4'hF);
    push_readback(`ADDR_PT_SELECT, 4'h7);
    push_entry(op_read_bad, 8'h01, 4'h0, 0, 4'h0);
    push_entry(op_read_bad, 8'h7F, 4'h0, 0, 4'h0);
    push_entry(op_read, `ADDR_TIMER_RESET, 4'h0, 0, 4'h0);
    // Clock timer count after 100 and then 300 ticks
    push_entry(op_ticks, 8'h00, 4'h0, 100, 4'h0);
    push_entry(op_read, `ADDR_CLK_LO, 4'h0, 0, 4'h4);
    push_entry(op_read, `ADDR_CLK_HI, 4'h0, 0, 4'h6);
    push_entry(op_ticks, 8'h00, 4'h0, 200, 4'h0);
    push_entry(op_read, `ADDR_CLK_LO, 4'h0, 0, 4'hC);
    push_entry(op_read, `ADDR_CLK_HI, 4'h0, 0, 4'h2);
    push_entry(op_write, `ADDR_TIMER_RESET, 4'h2, 0, 4'h0);
    push_entry(op_read, `ADDR_CLK_LO, 4'h0, 0, 4'h0);
    push_entry(op_read, `ADDR_CLK_HI, 4'h0, 0, 4'h0);
    // 128 ticks from zero pass the 32, 8 and 2 Hz falls
    push_entry(op_write, `ADDR_CLK_MASK, 4'hF, 0, 4'h0);
    push_entry(op_read_model, `ADDR_CLK_FACTOR, 4'h0, 0, 4'h0);
    push_entry(op_ticks, 8'h00, 4'h0, 128, 4'h0);
    push_entry(op_read, `ADDR_CLK_FACTOR, 4'h0, 0, 4'hE);
    // Programmable timer on tap 1 steps once per 4 ticks
    r = lcg_nibble();
    push_entry(op_write, `ADDR_PT_RELOAD_LO, r, 0, 4'h0);
    push_entry(op_write, `ADDR_PT_RELOAD_HI, 4'h0, 0, 4'h0);
    push_entry(op_write, `ADDR_PT_SELECT, 4'h1, 0, 4'h0);
    push_entry(op_write, `ADDR_PT_MASK, 4'h1, 0, 4'h0);
    push_entry(op_write, `ADDR_PT_CONTROL, 4'h3, 0, 4'h0);
    push_entry(op_read_model, `ADDR_PT_CNT_LO, 4'h0, 0, 4'h0);
    for (int i = 0; i <= int'(r); i++) begin
      push_entry(op_ticks, 8'h00, 4'h0, 4, 4'h0);
      push_entry(op_read_model, `ADDR_PT_CNT_LO, 4'h0, 0, 4'h0);
    end
    push_entry(op_read_model, `ADDR_PT_CNT_HI, 4'h0, 0, 4'h0);
    push_entry(op_read, `ADDR_PT_FACTOR, 4'h0, 0, 4'h1);
    push_entry(op_write, `ADDR_PT_CONTROL, 4'h0, 0, 4'h0);
    // K0 bits 3 and 1 fire on falling edges and only bits 1 and 0 are masked in
    push_entry(op_write, `ADDR_K0_RELATION, 4'hA, 0, 4'h0);
    push_entry(op_write, `ADDR_K0_MASK, 4'h3, 0, 4'h0);
    push_entry(op_read_model, `ADDR_K0_FACTOR, 4'h0, 0, 4'h0);
    push_entry(op_pins, 8'h00, 4'h4, 4, 4'h0);
    push_entry(op_read_model, `ADDR_K0_FACTOR, 4'h0, 0, 4'h0);
    push_entry(op_pins, 8'h00, 4'h5, 4, 4'h0);
    push_entry(op_read, `ADDR_K0_FACTOR, 4'h0, 0, 4'h1);
    push_entry(op_pins, 8'h00, 4'h7, 4, 4'h0);
    push_entry(op_read_model, `ADDR_K0_FACTOR, 4'h0, 0, 4'h0);
    push_entry(op_pins, 8'h00, 4'h5, 4, 4'h0);
    push_entry(op_read_model, `ADDR_K0_VALUE, 4'h0, 0, 4'h0);
    push_entry(op_read, `ADDR_K0_FACTOR, 4'h0, 0, 4'h1);
    push_entry(op_pins, 8'h00, 4'h0, 4, 4'h0);
    push_entry(op_read_model, `ADDR_K0_FACTOR, 4'h0, 0, 4'h0);
    push_entry(op_read_model, `ADDR_K0_VALUE, 4'h0, 0, 4'h0);
  endtask

  initial begin
    reset_n    = 1'b0;
    tick_256hz = 1'b0;
    k0         = '0;
    apb_req    = '0;
    exp_valid  = 1'b0;
    exp_data   = '0;
    exp_err    = 1'b0;
    irq_valid  = 1'b0;
    exp_irq    = '0;
    m          = '0;
    m.relation = 4'hF;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset_n = 1'b1;
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    $display("Checks done: %0d bus errors, %0d irq errors", bus_errors, irq_errors);
    if (bus_errors == 0 && irq_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Budget of count plus 4 cycles per entry plus reset and margin
  initial begin : watchdog
    int cycles;
    wait (table_ready);
    cycles = 50;
    foreach (table_q[i]) begin
      cycles += int'(table_q[i].count) + 4;
    end
    #(cycles * 20);
    $display("Watchdog expired after %0d cycles, the run hung", cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
